// ==== Makefile ====
TOP := vchess_ctrl_tb

all: run

run:
	verilator --binary --timing --assert -j 0 -f vchess_ctrl.f --top-module $(TOP) -o sim
	./obj_dir/sim

lint:
	verilator --lint-only -Wall verilog/vchess_pkg.sv verilog/axil_write_channel.sv \
		verilog/host_regs.sv verilog/status_read.sv verilog/vchess_ctrl.sv \
		--top-module vchess_ctrl

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// ==== dv/ctrl_patterns.txt ====
# op word_addr data: W write, R read and expect data, M read against model, N new inputs
# data is ignored for M and N
R 0001 00000000
R 0008 00000000
W 0008 12345678
W 000F 0badf00d
W 0002 00000fa5
W 0003 ffffffff
W 0001 00000123
W 0004 00000003
W 0000 00000003
R 000F 0badf00d
R 0002 000001a5
R 0003 0000007f
R 0001 00000023
R 0004 00000001
M 0000 00000000
M 0084 00000000
M 0086 00000000
M 008B 00000000
M 00B3 00000000
N 0000 00000000
M 0000 00000000
M 0088 00000000
M 008A 00000000
M 0085 00000000
M 0087 00000000
M 00AC 00000000
W 0040 ffffffff
R 0040 00000000

// ==== dv/vchess_ctrl_properties.sv ====
`timescale 1ns/1ns

module vchess_ctrl_properties
   import vchess_pkg::*;
(
   input logic      clk,
   input logic      arst_n,
   input axil_req_t bus_req,
   input axil_rsp_t bus_rsp,
   input wr_cmd_t   wr_cmd
);

   a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      bus_rsp.bvalid && !bus_req.bready |=> bus_rsp.bvalid)
      else $error("bvalid dropped before bready");

   a_rdata_hold: assert property (@(posedge clk) disable iff (!arst_n)
      bus_rsp.rvalid && !bus_req.rready |=> bus_rsp.rvalid && $stable(bus_rsp.rdata))
      else $error("Read response changed before rready");

   a_cmd_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      wr_cmd.valid |=> !wr_cmd.valid)
      else $error("Write command longer than one cycle");

   // Back-pressure while a write response waits
   a_aw_blocked: assert property (@(posedge clk) disable iff (!arst_n)
      bus_rsp.bvalid |-> !bus_rsp.awready && !bus_rsp.wready)
      else $error("Write accepted while bvalid high");

endmodule

bind vchess_ctrl vchess_ctrl_properties u_props (
   .clk     (clk),
   .arst_n  (arst_n),
   .bus_req (bus_req),
   .bus_rsp (bus_rsp),
   .wr_cmd  (wr_cmd)
);

// ==== dv/vchess_ctrl_tb.sv ====
`timescale 1ns/1ns

module vchess_ctrl_tb
   import vchess_pkg::*;
;

   logic            clk = 1'b0;
   logic            arst_n;
   axil_req_t       bus_req;
   axil_rsp_t       bus_rsp;
   root_status_t    root;
   movegen_status_t movegen;
   move_info_t      move;
   host_cmd_t       host;

   host_cmd_t       exp_host;  // Host register model
   byte             op_q[$];
   logic [13:0]     addr_q[$];
   logic [31:0]     data_q[$];
   int              cycle_count = 0;
   int              cycle_limit = 0;

   vchess_ctrl #(
      .ADDR_WIDTH (40)
   ) dut (
      .clk     (clk),
      .arst_n  (arst_n),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp),
      .root    (root),
      .movegen (movegen),
      .move    (move),
      .host    (host)
   );

   always #50 clk = ~clk;

   task abort_run();
      $display("CHECKS FAILED");
      $fatal(1, "Run stopped on first error");
   endtask

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit)
      begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         abort_run();
      end
   end

   task automatic check_word(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("FAILED at %0t ns: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_host(input host_cmd_t actual, input host_cmd_t expected);
      if (actual !== expected)
      begin
         $display("FAILED at %0t ns: host = 0x%h, expected 0x%h", $time, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic actual, input logic expected);
      if (actual !== expected)
      begin
         $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] actual,
                             input logic [1:0] expected);
      if (actual !== expected)
      begin
         $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic draw_inputs();
      logic [319:0] rnd;
      logic [31:0]  word;
      for (int i = 0; i < 10; i++)
         rnd[i*32 +: 32] = $urandom;
      move = move_info_t'(rnd[$bits(move_info_t)-1:0]);
      word = $urandom;
      root = root_status_t'(word[$bits(root_status_t)-1:0]);
      word = $urandom;
      movegen = movegen_status_t'(word[$bits(movegen_status_t)-1:0]);
   endtask

   task automatic model_write(input logic [13:0] addr, input logic [31:0] data);
      if (addr >= 14'h08 && addr <= 14'h0F)
         exp_host.new_board[addr[2:0]] = data;
      else
         case (addr)
            CTRL:
            begin
               exp_host.new_board_valid = data[0];
               exp_host.clear_moves     = data[1];
            end
            MOVE_INDEX: exp_host.move_index = data[7:0];
            POSITION:
            begin
               exp_host.new_position.white_to_move  = data[8];
               exp_host.new_position.castle_mask    = data[7:4];
               exp_host.new_position.en_passant_col = data[3:0];
            end
            HALF_MOVE:  exp_host.new_half_move = data[6:0];
            CAPTURE:    exp_host.capture_moves = data[0];
            default:    ;  // Read-only or unmapped
         endcase
   endtask

   function automatic logic [31:0] expect_word(input logic [13:0] addr);
      logic [31:0] w;
      w = '0;
      if (addr >= 14'h08 && addr <= 14'h0F)
         w = exp_host.new_board[addr[2:0]];
      else if (addr >= 14'hAC && addr <= 14'hB3)
         w = move.board[3'(addr - 14'hAC)];
      else
         case (addr)
            CTRL: w = {22'b0, root.insufficient_material, root.fifty_move, movegen.idle,
                       root.thrice_rep, root.mate, root.stalemate, movegen.move_ready,
                       movegen.moves_ready, exp_host.clear_moves, exp_host.new_board_valid};
            MOVE_INDEX:   w = {24'b0, exp_host.move_index};
            POSITION:     w = {23'b0, exp_host.new_position.white_to_move,
                               exp_host.new_position.castle_mask,
                               exp_host.new_position.en_passant_col};
            HALF_MOVE:    w = {25'b0, exp_host.new_half_move};
            CAPTURE:      w = {31'b0, exp_host.capture_moves};
            MV_FLAGS:     w = {26'b0, move.flags.insufficient_material, move.flags.fifty_move,
                               move.flags.thrice_rep, move.flags.black_in_check,
                               move.flags.white_in_check, move.flags.capture};
            MV_POSITION:  w = {23'b0, move.position.white_to_move, move.position.castle_mask,
                               move.position.en_passant_col};
            MV_EVAL:      w = {{8{move.eval[23]}}, move.eval};
            MOVE_COUNT:   w = {24'b0, movegen.move_count};
            ROOT_EVAL:    w = {{8{root.eval[23]}}, root.eval};
            MV_HALF_MOVE: w = {25'b0, move.half_move};
            MV_UCI:       w = {12'b0, move.uci.promotion, 1'b0, move.uci.to_row,
                               1'b0, move.uci.to_col, 1'b0, move.uci.from_row,
                               1'b0, move.uci.from_col};
            default:      w = '0;
         endcase
      return w;
   endfunction

   task automatic write_reg(input logic [13:0] addr, input logic [31:0] data);
      int hold;
      @(negedge clk);
      bus_req.awaddr  = 40'({addr, 2'b00});
      bus_req.wdata   = data;
      bus_req.wstrb   = 4'hF;
      bus_req.awvalid = 1'b1;
      bus_req.wvalid  = 1'b1;
      @(negedge clk);
      while (!bus_rsp.bvalid)
         @(negedge clk);
      check_resp("bresp", bus_rsp.bresp, 2'b00);  // OKAY
      model_write(addr, data);
      hold = int'($urandom % 4);
      if (hold == 0)
      begin
         bus_req.awvalid = 1'b0;
         bus_req.wvalid  = 1'b0;
      end
      // Same write stays offered, back-pressure must hold it off
      repeat (hold)
      begin
         @(negedge clk);
         check_flag("awready", bus_rsp.awready, 1'b0);
         check_flag("wready", bus_rsp.wready, 1'b0);
         check_flag("bvalid", bus_rsp.bvalid, 1'b1);
         check_host(host, exp_host);
      end
      bus_req.bready = 1'b1;
      @(negedge clk);
      if (hold != 0)
      begin
         while (!bus_rsp.bvalid)
            @(negedge clk);
         bus_req.awvalid = 1'b0;
         bus_req.wvalid  = 1'b0;
         @(negedge clk);
      end
      bus_req.bready = 1'b0;
      check_host(host, exp_host);
   endtask

   task automatic read_reg(input logic [13:0] addr, input logic [31:0] expected);
      int              hold;
      root_status_t    root_keep;
      movegen_status_t movegen_keep;
      move_info_t      move_keep;
      @(negedge clk);
      bus_req.araddr  = 40'({addr, 2'b00});
      bus_req.arvalid = 1'b1;
      @(negedge clk);
      while (!bus_rsp.rvalid)
         @(negedge clk);
      hold = int'($urandom % 4);
      if (hold == 0)
         bus_req.arvalid = 1'b0;
      root_keep    = root;
      movegen_keep = movegen;
      move_keep    = move;
      if (hold != 0)
         draw_inputs();  // Held response must not follow its source
      repeat (hold)
      begin
         @(negedge clk);
         check_flag("arready", bus_rsp.arready, 1'b0);  // Second read waits
         check_word("rdata", bus_rsp.rdata, expected);
      end
      if (hold != 0)
      begin
         root    = root_keep;
         movegen = movegen_keep;
         move    = move_keep;
         bus_req.rready = 1'b1;
         @(negedge clk);  // First response out, second read taken
         bus_req.arvalid = 1'b0;
      end
      check_flag("rvalid", bus_rsp.rvalid, 1'b1);
      check_resp("rresp", bus_rsp.rresp, 2'b00);
      check_word("rdata", bus_rsp.rdata, expected);
      bus_req.rready = 1'b1;
      @(negedge clk);
      bus_req.rready = 1'b0;
   endtask

   task automatic load_patterns();
      int          fd;
      string       line;
      string       op;
      logic [13:0] addr;
      logic [31:0] data;
      fd = $fopen("dv/ctrl_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open pattern file dv/ctrl_patterns.txt");
         abort_run();
      end
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 0 && line[0] != "#" && $sscanf(line, "%s %h %h", op, addr, data) == 3)
         begin
            op_q.push_back(op[0]);
            addr_q.push_back(addr);
            data_q.push_back(data);
         end
      end
      $fclose(fd);
   endtask

   initial
   begin
      void'($urandom(32'hde1bebf1));
      arst_n   = 1'b0;
      bus_req  = '0;
      exp_host = '0;
      draw_inputs();
      load_patterns();
      cycle_limit = op_q.size() * 20 + 50;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check_host(host, exp_host);
      check_flag("bvalid", bus_rsp.bvalid, 1'b0);
      check_flag("rvalid", bus_rsp.rvalid, 1'b0);
      check_flag("awready", bus_rsp.awready, 1'b0);
      check_flag("wready", bus_rsp.wready, 1'b0);
      check_flag("arready", bus_rsp.arready, 1'b1);
      foreach (op_q[i])
      begin
         case (op_q[i])
            "W": write_reg(addr_q[i], data_q[i]);
            "R": read_reg(addr_q[i], data_q[i]);
            "M": read_reg(addr_q[i], expect_word(addr_q[i]));
            "N":
            begin
               @(negedge clk);
               draw_inputs();
            end
            default:
            begin
               $display("Unknown operation in pattern line %0d", i);
               abort_run();
            end
         endcase
      end
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// ==== vchess_ctrl.f ====
verilog/vchess_pkg.sv
verilog/axil_write_channel.sv
verilog/host_regs.sv
verilog/status_read.sv
verilog/vchess_ctrl.sv
dv/vchess_ctrl_properties.sv
dv/vchess_ctrl_tb.sv

// ==== verilog/axil_write_channel.sv ====
`timescale 1ns/1ns

module axil_write_channel
   import vchess_pkg::*;
#(
   parameter int ADDR_WIDTH = AXIL_ADDR_WIDTH
)
(
   input  logic      clk,
   input  logic      arst_n,
   input  axil_req_t req,
   output logic      aw_w_ready,
   output logic      bvalid,
   output wr_cmd_t   cmd
);

   wr_state_e                  state;
   logic [ADDR_WIDTH-1:0]      awaddr;
   logic                       cmd_valid;
   logic [WORD_ADDR_WIDTH-1:0] cmd_addr;
   logic [DATA_WIDTH-1:0]      cmd_data;

   assign awaddr = req.awaddr[ADDR_WIDTH-1:0];

   // Address and data are taken only as a pair
   assign aw_w_ready = (state == IDLE) && req.awvalid && req.wvalid;

   assign bvalid = (state == RESP);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= IDLE;
         cmd_valid <= 1'b0;
      end
      else
      begin
         cmd_valid <= aw_w_ready;  // Single cycle strobe
         case (state)
            IDLE:
            begin
               if (aw_w_ready)
                  state <= RESP;
            end
            RESP:
            begin
               if (req.bready)
                  state <= IDLE;
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (aw_w_ready)
      begin
         cmd_addr <= awaddr[15:2];  // Word address
         cmd_data <= req.wdata;     // Strobes not used
      end
   end

   assign cmd = '{valid: cmd_valid, addr: cmd_addr, data: cmd_data};

endmodule

// ==== verilog/host_regs.sv ====
`timescale 1ns/1ns

module host_regs
   import vchess_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  wr_cmd_t   cmd,
   output host_cmd_t regs
);

   reg_addr_e  wr_addr;
   logic [2:0] rank_sel;

   assign wr_addr  = reg_addr_e'(cmd.addr);
   assign rank_sel = cmd.addr[2:0];  // BOARD_RANK0 is 8-aligned

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         regs <= '0;
      end
      else if (cmd.valid)
      begin
         case (wr_addr)
            CTRL:
            begin
               // Level bits, host sets and clears them
               regs.new_board_valid <= cmd.data[0];
               regs.clear_moves     <= cmd.data[1];
            end
            MOVE_INDEX:
            begin
               regs.move_index <= cmd.data[MOVE_INDEX_WIDTH-1:0];
            end
            POSITION:
            begin
               regs.new_position <= position_t'(cmd.data[$bits(position_t)-1:0]);
            end
            HALF_MOVE:
            begin
               regs.new_half_move <= cmd.data[HALF_MOVE_WIDTH-1:0];
            end
            CAPTURE:
            begin
               regs.capture_moves <= cmd.data[0];
            end
            BOARD_RANK0, BOARD_RANK1, BOARD_RANK2, BOARD_RANK3,
            BOARD_RANK4, BOARD_RANK5, BOARD_RANK6, BOARD_RANK7:
            begin
               regs.new_board[rank_sel] <= rank_t'(cmd.data);
            end
            default:
            begin
               // Read-only and unmapped words
               regs <= regs;
            end
         endcase
      end
   end

endmodule

// ==== verilog/status_read.sv ====
`timescale 1ns/1ns

module status_read
   import vchess_pkg::*;
#(
   parameter int ADDR_WIDTH = AXIL_ADDR_WIDTH
)
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  axil_req_t             req,
   input  host_cmd_t             regs,
   input  root_status_t          root,
   input  movegen_status_t       movegen,
   input  move_info_t            move,
   output logic                  arready,
   output logic                  rvalid,
   output logic [DATA_WIDTH-1:0] rdata
);

   logic [ADDR_WIDTH-1:0]      araddr;
   logic [WORD_ADDR_WIDTH-1:0] word_addr;
   logic [2:0]                 mv_rank_sel;
   logic                       ar_hs;
   logic [DATA_WIDTH-1:0]      rd_word;

   function automatic logic [DATA_WIDTH-1:0] sext_eval(input logic [EVAL_WIDTH-1:0] eval);
      return {{(DATA_WIDTH-EVAL_WIDTH){eval[EVAL_WIDTH-1]}}, eval};
   endfunction

   assign araddr      = req.araddr[ADDR_WIDTH-1:0];
   assign word_addr   = araddr[15:2];
   assign mv_rank_sel = 3'(word_addr - MV_RANK0);

   // A pending response blocks the next address
   assign arready = !rvalid || req.rready;
   assign ar_hs   = arready && req.arvalid;

   always_comb
   begin
      rd_word = '0;
      case (reg_addr_e'(word_addr))
         CTRL:
         begin
            rd_word[0] = regs.new_board_valid;
            rd_word[1] = regs.clear_moves;
            rd_word[2] = movegen.moves_ready;
            rd_word[3] = movegen.move_ready;
            rd_word[4] = root.stalemate;
            rd_word[5] = root.mate;
            rd_word[6] = root.thrice_rep;
            rd_word[7] = movegen.idle;
            rd_word[8] = root.fifty_move;
            rd_word[9] = root.insufficient_material;
         end
         MOVE_INDEX:   rd_word = DATA_WIDTH'(regs.move_index);
         POSITION:     rd_word = DATA_WIDTH'(regs.new_position);
         HALF_MOVE:    rd_word = DATA_WIDTH'(regs.new_half_move);
         CAPTURE:      rd_word = DATA_WIDTH'(regs.capture_moves);
         BOARD_RANK0, BOARD_RANK1, BOARD_RANK2, BOARD_RANK3,
         BOARD_RANK4, BOARD_RANK5, BOARD_RANK6, BOARD_RANK7:
         begin
            rd_word = regs.new_board[word_addr[2:0]];
         end
         MV_FLAGS:     rd_word = DATA_WIDTH'(move.flags);
         MV_POSITION:  rd_word = DATA_WIDTH'(move.position);
         MV_EVAL:      rd_word = sext_eval(move.eval);
         MOVE_COUNT:   rd_word = DATA_WIDTH'(movegen.move_count);
         ROOT_EVAL:    rd_word = sext_eval(root.eval);
         MV_HALF_MOVE: rd_word = DATA_WIDTH'(move.half_move);
         MV_UCI:
         begin
            // One square coordinate per nibble
            rd_word = {{(DATA_WIDTH-UCI_WIDTH-4){1'b0}}, move.uci.promotion,
                       1'b0, move.uci.to_row, 1'b0, move.uci.to_col,
                       1'b0, move.uci.from_row, 1'b0, move.uci.from_col};
         end
         MV_RANK0, MV_RANK1, MV_RANK2, MV_RANK3,
         MV_RANK4, MV_RANK5, MV_RANK6, MV_RANK7:
         begin
            rd_word = move.board[mv_rank_sel];
         end
         default:      rd_word = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         rvalid <= 1'b0;
      else if (ar_hs)
         rvalid <= 1'b1;
      else if (req.rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (ar_hs)
         rdata <= rd_word;  // Sampled at the address handshake
   end

endmodule

// ==== verilog/vchess_ctrl.sv ====
`timescale 1ns/1ns

module vchess_ctrl
   import vchess_pkg::*;
#(
   parameter int ADDR_WIDTH = 40
)
(
   input  logic            clk,
   input  logic            arst_n,
   input  axil_req_t       bus_req,
   output axil_rsp_t       bus_rsp,
   input  root_status_t    root,
   input  movegen_status_t movegen,
   input  move_info_t      move,
   output host_cmd_t       host
);

   logic                  aw_w_ready;
   logic                  bvalid;
   wr_cmd_t               wr_cmd;
   logic                  arready;
   logic                  rvalid;
   logic [DATA_WIDTH-1:0] rdata;

   // Word address decode needs byte address bits 15:2
   if (ADDR_WIDTH < 16 || ADDR_WIDTH > AXIL_ADDR_WIDTH)
   begin : g_addr_width_check
      $error("ADDR_WIDTH out of range 16 to %0d", AXIL_ADDR_WIDTH);
   end

   axil_write_channel #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) u_write (
      .clk        (clk),
      .arst_n     (arst_n),
      .req        (bus_req),
      .aw_w_ready (aw_w_ready),
      .bvalid     (bvalid),
      .cmd        (wr_cmd)
   );

   host_regs u_regs (
      .clk    (clk),
      .arst_n (arst_n),
      .cmd    (wr_cmd),
      .regs   (host)
   );

   status_read #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) u_read (
      .clk     (clk),
      .arst_n  (arst_n),
      .req     (bus_req),
      .regs    (host),
      .root    (root),
      .movegen (movegen),
      .move    (move),
      .arready (arready),
      .rvalid  (rvalid),
      .rdata   (rdata)
   );

   assign bus_rsp = '{
      awready: aw_w_ready,
      wready:  aw_w_ready,
      bvalid:  bvalid,
      bresp:   AXI_RESP_OKAY,
      arready: arready,
      rvalid:  rvalid,
      rdata:   rdata,
      rresp:   AXI_RESP_OKAY
   };

endmodule

// ==== verilog/vchess_pkg.sv ====
package vchess_pkg;

   localparam int DATA_WIDTH       = 32;
   localparam int AXIL_ADDR_WIDTH  = 40;  // Widest supported bus address
   localparam int WORD_ADDR_WIDTH  = 14;  // Byte address bits 15:2
   localparam int PIECE_WIDTH      = 4;
   localparam int EVAL_WIDTH       = 24;
   localparam int MOVE_INDEX_WIDTH = 8;
   localparam int HALF_MOVE_WIDTH  = 7;
   localparam int UCI_WIDTH        = 16;

   localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

   typedef logic [PIECE_WIDTH-1:0] piece_t;
   typedef piece_t [7:0] rank_t;  // One rank fills a bus word
   typedef rank_t [7:0] board_t;

   typedef struct packed {
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;
   } position_t;

   typedef struct packed {
      logic                         mate;
      logic                         stalemate;
      logic                         thrice_rep;
      logic                         fifty_move;
      logic                         insufficient_material;
      logic signed [EVAL_WIDTH-1:0] eval;
   } root_status_t;

   typedef struct packed {
      logic                        idle;
      logic                        moves_ready;
      logic                        move_ready;  // Indexed move result valid
      logic [MOVE_INDEX_WIDTH-1:0] move_count;
   } movegen_status_t;

   // Ordered to match the MV_FLAGS readback, high bit first
   typedef struct packed {
      logic insufficient_material;
      logic fifty_move;
      logic thrice_rep;
      logic black_in_check;
      logic white_in_check;
      logic capture;
   } move_flags_t;

   typedef struct packed {
      logic [3:0] promotion;
      logic [2:0] to_row;
      logic [2:0] to_col;
      logic [2:0] from_row;
      logic [2:0] from_col;
   } uci_t;

   typedef struct packed {
      board_t                       board;
      position_t                    position;
      logic signed [EVAL_WIDTH-1:0] eval;
      move_flags_t                  flags;
      logic [HALF_MOVE_WIDTH-1:0]   half_move;
      uci_t                         uci;
   } move_info_t;

   typedef struct packed {
      logic                        new_board_valid;
      logic                        clear_moves;
      logic                        capture_moves;
      logic [MOVE_INDEX_WIDTH-1:0] move_index;
      board_t                      new_board;
      position_t                   new_position;
      logic [HALF_MOVE_WIDTH-1:0]  new_half_move;
   } host_cmd_t;

   typedef struct packed {
      logic [AXIL_ADDR_WIDTH-1:0] awaddr;
      logic                       awvalid;
      logic [DATA_WIDTH-1:0]      wdata;
      logic [DATA_WIDTH/8-1:0]    wstrb;
      logic                       wvalid;
      logic                       bready;
      logic [AXIL_ADDR_WIDTH-1:0] araddr;
      logic                       arvalid;
      logic                       rready;
   } axil_req_t;

   typedef struct packed {
      logic                  awready;
      logic                  wready;
      logic                  bvalid;
      logic [1:0]            bresp;
      logic                  arready;
      logic                  rvalid;
      logic [DATA_WIDTH-1:0] rdata;
      logic [1:0]            rresp;
   } axil_rsp_t;

   typedef struct packed {
      logic                       valid;
      logic [WORD_ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0]      data;
   } wr_cmd_t;

   typedef enum logic [WORD_ADDR_WIDTH-1:0] {
      CTRL         = 14'h00,
      MOVE_INDEX   = 14'h01,
      POSITION     = 14'h02,
      HALF_MOVE    = 14'h03,
      CAPTURE      = 14'h04,
      BOARD_RANK0  = 14'h08,
      BOARD_RANK1  = 14'h09,
      BOARD_RANK2  = 14'h0A,
      BOARD_RANK3  = 14'h0B,
      BOARD_RANK4  = 14'h0C,
      BOARD_RANK5  = 14'h0D,
      BOARD_RANK6  = 14'h0E,
      BOARD_RANK7  = 14'h0F,
      MV_FLAGS     = 14'h84,
      MV_POSITION  = 14'h85,
      MV_EVAL      = 14'h86,
      MOVE_COUNT   = 14'h87,
      ROOT_EVAL    = 14'h88,
      MV_HALF_MOVE = 14'h8A,
      MV_UCI       = 14'h8B,
      MV_RANK0     = 14'hAC,
      MV_RANK1     = 14'hAD,
      MV_RANK2     = 14'hAE,
      MV_RANK3     = 14'hAF,
      MV_RANK4     = 14'hB0,
      MV_RANK5     = 14'hB1,
      MV_RANK6     = 14'hB2,
      MV_RANK7     = 14'hB3
   } reg_addr_e;

   typedef enum logic {
      IDLE,
      RESP
   } wr_state_e;

endpackage
